// ==== busSystem.f ====
verilog/busPkg.sv
verilog/memPkg.sv
verilog/nxmMonitor.sv
verilog/memController.sv
verilog/ioRegs.sv
verilog/busSystem.sv
test/busSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus slice testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f busSystem.f \
   --top-module busSystemTb \
   -o busSystemSim

status=0
./obj_dir/busSystemSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

echo "Simulation finished cleanly"

// ==== test/busSystemTb.sv ====
////////////////////////////////////////
// Bus slice testbench
// Memory, device register and NXM checks
////////////////////////////////////////

`timescale 1ns/1ps

module busSystemTb;
   import busPkg::*;
   import memPkg::*;

   // Wait loop limit in cycles
   localparam int ackTimeout = 40;
   // Watch window for an unanswered I/O cycle
   localparam int ioWatch = 20;

   logic    clk;
   logic    rst;
   logic    busReq;
   busReqT  busReqData;
   logic    busAck;
   busWordT busRdData;
   logic    memWait;
   logic    nxmIntr;
   busAddrU nxmAddr;

   // Scoreboard models
   busWordT     memModel [memWords];
   busWordT     regModel [4];
   logic [17:0] wrAddrs [$];

   logic [31:0] rngState = 32'h94f55003;
   string       testName = "init";
   int          errCount = 0;
   int          checkCount = 0;
   int          testErrs = 0;
   int          testBase = 0;
   int          testCount = 0;

   busSystem UUT
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .busReqData (busReqData),
      .busAck     (busAck),
      .busRdData  (busRdData),
      .memWait    (memWait),
      .nxmIntr    (nxmIntr),
      .nxmAddr    (nxmAddr)
   );

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // Protocol assertions
   ////////////////////////////////////////

   // NXM interrupt lasts one cycle
   nxmOnePulse: assert property (@(posedge clk) disable iff (rst) nxmIntr |=> !nxmIntr)
   else
   begin
      $display("ERROR %s nxmIntr after pulse expected 0 actual 1", testName);
      errCount++;
      testErrs++;
   end

   // Wait drops in the interrupt cycle
   waitDownAtNxm: assert property (@(posedge clk) disable iff (rst) nxmIntr |-> !memWait)
   else
   begin
      $display("ERROR %s memWait at nxmIntr expected 0 actual 1", testName);
      errCount++;
      testErrs++;
   end

   // Wait only opens right after a strobe
   waitAfterStrobe: assert property (@(posedge clk) disable iff (rst)
                                     $rose(memWait) |-> $past(busReq))
   else
   begin
      $display("%s: memWait rose without a preceding strobe", testName);
      errCount++;
      testErrs++;
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] randNext();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   // Full 36-bit random data word
   function automatic busWordT randWord();
      logic [31:0] hi;
      hi = randNext();
      return {hi[3:0], randNext()};
   endfunction

   function automatic busAddrU memAddrOf(input logic rd, input logic wr,
                                         input logic [17:0] wa);
      busAddrU a;
      a = '0;
      a.mem.flags.rd = rd;
      a.mem.flags.wr = wr;
      a.mem.wordAddr = wa;
      return a;
   endfunction

   function automatic busAddrU ioAddrOf(input logic rd, input logic wr,
                                        input logic [3:0] ctl, input logic [1:0] regSel);
      busAddrU a;
      a = '0;
      a.io.flags.rd = rd;
      a.io.flags.wr = wr;
      a.io.flags.io = 1'b1;
      a.io.ctlNum = ctl;
      a.io.regNum = regSel;
      return a;
   endfunction

   // Just past the next rising edge
   task automatic stepCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic checkValue(input string what, input logic [35:0] expected,
                             input logic [35:0] actual);
      checkCount++;
      assert (actual === expected)
      else
      begin
         $display("ERROR %s %s expected %0h actual %0h", testName, what, expected, actual);
         errCount++;
         testErrs++;
      end
   endtask

   task automatic startTest(input string name);
      testName = name;
      testErrs = 0;
      testBase = checkCount;
      testCount++;
   endtask

   task automatic endTest();
      $display("%-10s %0d checks, %0d errors", testName, checkCount - testBase, testErrs);
   endtask

   // One-cycle strobe with its request
   task automatic issueCycle(input busAddrU addr, input busWordT wdata);
      busReq = 1'b1;
      busReqData.addr = addr;
      busReqData.wrData = wdata;
      stepCycle();
      busReq = 1'b0;
      busReqData = '0;
   endtask

   // Cycle 1 is the one after the strobe
   task automatic awaitAck(output int lat, output busWordT rdata, output int waits,
                           output int nxms);
      int n;
      n = 1;
      lat = 0;
      waits = 0;
      nxms = 0;
      rdata = '0;
      while (lat == 0 && n <= ackTimeout)
      begin
         if (memWait)
            waits++;
         if (nxmIntr)
            nxms++;
         if (busAck)
         begin
            lat = n;
            rdata = busRdData;
         end
         else
         begin
            stepCycle();
            n++;
         end
      end
      if (lat == 0)
      begin
         $display("%s: no acknowledge within %0d cycles", testName, ackTimeout);
         errCount++;
         testErrs++;
      end
   endtask

   task automatic memAccess(input busAddrU addr, input busWordT wdata,
                            output busWordT rdata);
      int lat;
      int waits;
      int nxms;
      issueCycle(addr, wdata);
      awaitAck(lat, rdata, waits, nxms);
      checkValue("ack latency", 36'(memWaitStates), 36'(lat));
      checkValue("wait cycles", 36'(memWaitStates), 36'(waits));
      checkValue("nxm pulses", '0, 36'(nxms));
      // Window closed by the ack
      stepCycle();
      checkValue("wait after ack", '0, 36'(memWait));
      // Read data bus idles at zero
      checkValue("idle read data", '0, busRdData);
   endtask

   task automatic ioAccess(input busAddrU addr, input busWordT wdata,
                           output busWordT rdata);
      int lat;
      int waits;
      int nxms;
      issueCycle(addr, wdata);
      awaitAck(lat, rdata, waits, nxms);
      checkValue("ack latency", 36'(1), 36'(lat));
      checkValue("wait cycles", '0, 36'(waits));
      checkValue("nxm pulses", '0, 36'(nxms));
      stepCycle();
   endtask

   // Unanswered memory cycle that runs to the interrupt
   task automatic nxmAccess(input busAddrU addr, input busWordT wdata);
      int n;
      int fired;
      int waits;
      int acks;
      n = 1;
      fired = 0;
      waits = 0;
      acks = 0;
      issueCycle(addr, wdata);
      while (fired == 0 && n <= ackTimeout)
      begin
         if (memWait)
            waits++;
         if (busAck)
            acks++;
         if (nxmIntr)
            fired = n;
         else
         begin
            stepCycle();
            n++;
         end
      end
      if (fired == 0)
      begin
         $display("%s: no NXM interrupt within %0d cycles", testName, ackTimeout);
         errCount++;
         testErrs++;
      end
      else
      begin
         checkValue("nxm latency", 36'(nxmTimeout), 36'(fired));
         checkValue("wait cycles", 36'(nxmTimeout - 1), 36'(waits));
         checkValue("acks", '0, 36'(acks));
         checkValue("nxmAddr", addr, nxmAddr);
         stepCycle();
         checkValue("nxmIntr after pulse", '0, 36'(nxmIntr));
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      logic [31:0] r;
      logic [17:0] wa;
      logic [3:0]  ctl;
      busWordT     wd;
      busWordT     rd;
      busAddrU     lastNxm;
      int          acks;
      int          nxms;
      int          waits;

      busReq = 1'b0;
      busReqData = '0;
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      startTest("reset");
      checkValue("busAck", '0, 36'(busAck));
      checkValue("memWait", '0, 36'(memWait));
      checkValue("nxmIntr", '0, 36'(nxmIntr));
      checkValue("nxmAddr", '0, nxmAddr);
      stepCycle();
      endTest();

      // Writes first, then read everything back
      startTest("memRW");
      for (int i = 0; i < 8; i++)
      begin
         r = randNext();
         wa = 18'(r[memAddrBits-1:0]);
         wd = randWord();
         memAccess(memAddrOf(1'b0, 1'b1, wa), wd, rd);
         memModel[wa[memAddrBits-1:0]] = wd;
         wrAddrs.push_back(wa);
      end
      foreach (wrAddrs[i])
      begin
         memAccess(memAddrOf(1'b1, 1'b0, wrAddrs[i]), '0, rd);
         checkValue("read data", memModel[wrAddrs[i][memAddrBits-1:0]], rd);
      end
      endTest();

      // Bit 10 set puts the address at or above 1024
      startTest("nxm");
      r = randNext();
      wa = r[17:0] | 18'h00400;
      nxmAccess(memAddrOf(1'b1, 1'b0, wa), '0);
      r = randNext();
      wa = r[17:0] | 18'h00400;
      lastNxm = memAddrOf(1'b0, 1'b1, wa);
      nxmAccess(lastNxm, randWord());
      endTest();

      // Good access straight after the NXM keeps the failing address
      startTest("recovery");
      r = randNext();
      wa = 18'(r[memAddrBits-1:0]);
      wd = randWord();
      memAccess(memAddrOf(1'b0, 1'b1, wa), wd, rd);
      memModel[wa[memAddrBits-1:0]] = wd;
      memAccess(memAddrOf(1'b1, 1'b0, wa), '0, rd);
      checkValue("read data", memModel[wa[memAddrBits-1:0]], rd);
      checkValue("nxmAddr held", lastNxm, nxmAddr);
      endTest();

      // Cleared at reset, then written
      startTest("ioRegs");
      for (int i = 0; i < 4; i++)
      begin
         regModel[i] = '0;
         ioAccess(ioAddrOf(1'b1, 1'b0, 4'(ioCtlNum), 2'(i)), '0, rd);
         checkValue("register reset", regModel[i], rd);
         wd = randWord();
         ioAccess(ioAddrOf(1'b0, 1'b1, 4'(ioCtlNum), 2'(i)), wd, rd);
         regModel[i] = wd;
      end
      for (int i = 3; i >= 0; i--)
      begin
         ioAccess(ioAddrOf(1'b1, 1'b0, 4'(ioCtlNum), 2'(i)), '0, rd);
         checkValue("register read", regModel[i], rd);
      end
      endTest();

      // Strobe to a controller nobody answers
      startTest("ioNoAck");
      r = randNext();
      ctl = (r[3:0] == 4'(ioCtlNum)) ? ~r[3:0] : r[3:0];
      issueCycle(ioAddrOf(1'b1, 1'b0, ctl, r[5:4]), '0);
      acks = 0;
      nxms = 0;
      waits = 0;
      for (int i = 0; i < ioWatch; i++)
      begin
         if (busAck)
            acks++;
         if (nxmIntr)
            nxms++;
         if (memWait)
            waits++;
         stepCycle();
      end
      checkValue("acks", '0, 36'(acks));
      checkValue("nxm pulses", '0, 36'(nxms));
      checkValue("wait cycles", '0, 36'(waits));
      endTest();

      $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== verilog/busPkg.sv ====
////////////////////////////////////////
// Backplane bus types
// Address word views and request bundle
////////////////////////////////////////

package busPkg;

   ////////////////////////////////////////
   // Data word
   ////////////////////////////////////////

   // One 36-bit bus word
   typedef logic [35:0] busWordT;

   ////////////////////////////////////////
   // Address word
   ////////////////////////////////////////

   // Cycle type flags, top nibble of the address word
   typedef struct packed {
      logic rd;               // Read cycle
      logic wr;               // Write cycle
      logic io;               // Set for I/O, clear for memory
      logic rsvd;
   } busFlagsT;

   // Memory view of the address word
   typedef struct packed {
      busFlagsT    flags;
      logic [13:0] spare;
      logic [17:0] wordAddr;  // 18-bit word address
   } memAddrT;

   // I/O view of the same word
   typedef struct packed {
      busFlagsT    flags;
      logic [13:0] spare;
      logic [3:0]  ctlNum;    // Controller number
      logic [11:0] spareLo;
      logic [1:0]  regNum;    // Device register select
   } ioAddrT;

   // Both views overlay one 36-bit word
   typedef union packed {
      memAddrT mem;
      ioAddrT  io;
   } busAddrU;

   // Request that travels with the strobe
   typedef struct packed {
      busAddrU addr;
      busWordT wrData;
   } busReqT;

endpackage

// ==== verilog/busSystem.sv ====
////////////////////////////////////////
// Bus slice top level
// Memory, device registers, NXM monitor
////////////////////////////////////////

`timescale 1ns/1ps

module busSystem
(
   input  logic            clk,
   input  logic            rst,
   input  logic            busReq,
   input  busPkg::busReqT  busReqData,
   output logic            busAck,
   output busPkg::busWordT busRdData,
   output logic            memWait,
   output logic            nxmIntr,
   output busPkg::busAddrU nxmAddr
);
   import busPkg::*;

   logic    memAck;
   logic    ioAck;
   busWordT memRdData;
   busWordT ioRdData;

   ////////////////////////////////////////
   // Targets
   ////////////////////////////////////////

   // Strobe and request fan out unchanged
   // Each target decodes its own view
   memController memCtl
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .busReqData (busReqData),
      .memAck     (memAck),
      .memRdData  (memRdData)
   );

   ioRegs devRegs
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .busReqData (busReqData),
      .ioAck      (ioAck),
      .ioRdData   (ioRdData)
   );

   ////////////////////////////////////////
   // Response merge
   ////////////////////////////////////////

   // At most one target answers
   assign busAck = memAck | ioAck;

   // Data from whoever acked, zero when idle
   assign busRdData = memAck ? memRdData :
                      ioAck  ? ioRdData  : '0;

   ////////////////////////////////////////
   // Bus monitor
   ////////////////////////////////////////

   // Watches the merged ack
   nxmMonitor monitor
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .busReqData (busReqData),
      .busAck     (busAck),
      .memWait    (memWait),
      .nxmIntr    (nxmIntr),
      .nxmAddr    (nxmAddr)
   );

   // Address decode keeps the two targets apart
   oneTarget: assert property (@(posedge clk) disable iff (rst) !(memAck && ioAck));

endmodule

// ==== verilog/ioRegs.sv ====
////////////////////////////////////////
// Device register block
// Four read/write registers on one controller
////////////////////////////////////////

`timescale 1ns/1ps

module ioRegs
(
   input  logic            clk,
   input  logic            rst,
   input  logic            busReq,
   input  busPkg::busReqT  busReqData,
   output logic            ioAck,
   output busPkg::busWordT ioRdData
);
   import busPkg::*;
   import memPkg::*;

   // Register file, indexed by regNum
   busWordT [3:0] regFile;
   ioAddrT        ioView;
   logic          hit;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   // I/O view of the address word
   assign ioView = busReqData.addr.io;

   // I/O cycle to our controller number
   // Other controllers are left unanswered
   assign hit = busReq && ioView.flags.io && (ioView.ctlNum == 4'(ioCtlNum));

   ////////////////////////////////////////
   // Registers and ack
   ////////////////////////////////////////

   // Registers come up cleared
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ioAck   <= 1'b0;
         regFile <= '0;
      end
      else
      begin
         // Ack the cycle after the strobe
         ioAck <= hit;
         if (hit && ioView.flags.wr)
            regFile[ioView.regNum] <= busReqData.wrData;
      end
   end

   // Read data alongside the ack
   // Returns the value before any same-cycle write
   always_ff @(posedge clk)
   begin
      if (hit && ioView.flags.rd)
         ioRdData <= regFile[ioView.regNum];
   end

endmodule

// ==== verilog/memController.sv ====
////////////////////////////////////////
// Memory controller
// Fixed wait states, installed words only
////////////////////////////////////////

`timescale 1ns/1ps

module memController
(
   input  logic            clk,
   input  logic            rst,
   input  logic            busReq,
   input  busPkg::busReqT  busReqData,
   output logic            memAck,
   output busPkg::busWordT memRdData
);
   import busPkg::*;
   import memPkg::*;

   // Installed storage
   busWordT                memArray [memWords];

   // One valid bit per wait state
   logic [memWaitStates-1:0] vld;
   busReqT                   curReq;
   logic                     accept;
   logic [memAddrBits-1:0]   curIdx;
   logic                     lastStage;
   logic                     readStage;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   // Memory cycle that hits installed words
   // Anything above stays silent for the monitor to catch
   assign accept = busReq && !busReqData.addr.mem.flags.io
                   && (busReqData.addr.mem.wordAddr < 18'(memWords));

   // Request held for the whole cycle
   always_ff @(posedge clk)
   begin
      if (accept)
         curReq <= busReqData;
   end

   assign curIdx = curReq.addr.mem.wordAddr[memAddrBits-1:0];

   ////////////////////////////////////////
   // Wait state shift
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         vld <= '0;
      else
         vld <= {vld[memWaitStates-2:0], accept};
   end

   // Ack on the last stage
   assign lastStage = vld[memWaitStates-1];
   // Stage before, so read data lands with the ack
   assign readStage = vld[memWaitStates-2];
   assign memAck    = lastStage;

   ////////////////////////////////////////
   // Array access
   ////////////////////////////////////////

   // Write commits at the end of the ack cycle
   always_ff @(posedge clk)
   begin
      if (lastStage && curReq.addr.mem.flags.wr)
         memArray[curIdx] <= curReq.wrData;
   end

   // Synchronous read, valid in the ack cycle
   always_ff @(posedge clk)
   begin
      if (readStage && curReq.addr.mem.flags.rd)
         memRdData <= memArray[curIdx];
   end

   // One cycle in flight, no new strobe until the shift drains
   shiftIdle: assert property (@(posedge clk) disable iff (rst) busReq |-> (vld == '0));

endmodule

// ==== verilog/memPkg.sv ====
////////////////////////////////////////
// Memory and bus monitor sizing
////////////////////////////////////////

package memPkg;

   // Installed memory, in words
   localparam int memWords = 1024;
   // Array index width
   localparam int memAddrBits = $clog2(memWords);

   // Cycles from strobe to memory acknowledge
   localparam int memWaitStates = 3;

   // Monitor window before NXM is declared
   localparam int nxmTimeout = 15;
   // Counter width for the window
   localparam int nxmCntBits = $clog2(nxmTimeout + 1);

   // Controller number of the device register block
   localparam int ioCtlNum = 3;

endpackage

// ==== verilog/nxmMonitor.sv ====
////////////////////////////////////////
// NXM bus monitor
// Times memory cycles, flags the unanswered
////////////////////////////////////////

`timescale 1ns/1ps

module nxmMonitor
(
   input  logic            clk,
   input  logic            rst,
   input  logic            busReq,
   input  busPkg::busReqT  busReqData,
   input  logic            busAck,
   output logic            memWait,
   output logic            nxmIntr,
   output busPkg::busAddrU nxmAddr
);
   import busPkg::*;
   import memPkg::*;

   logic                  memStrobe;
   logic [nxmCntBits-1:0] timeout;
   busAddrU               curAddr;

   // Only memory cycles are watched, I/O is ignored
   assign memStrobe = busReq && !busReqData.addr.mem.flags.io;

   ////////////////////////////////////////
   // Timeout counter
   ////////////////////////////////////////

   // Load on strobe, clear on ack, else run down to zero
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         timeout <= '0;
      else if (memStrobe)
         timeout <= nxmCntBits'(nxmTimeout);
      else if (busAck)
         timeout <= '0;
      else if (timeout != '0)
         timeout <= timeout - 1'b1;
   end

   // Wait spans the open window, drops in the NXM cycle
   assign memWait = (timeout > nxmCntBits'(1));
   // Last count of the window means nobody answered
   assign nxmIntr = (timeout == nxmCntBits'(1));

   ////////////////////////////////////////
   // Failing address
   ////////////////////////////////////////

   // Address of the cycle in flight
   always_ff @(posedge clk)
   begin
      if (memStrobe)
         curAddr <= busReqData.addr;
   end

   // Latched as the count passes to 1 so it shows with nxmIntr
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         nxmAddr <= '0;
      else if ((timeout == nxmCntBits'(2)) && !busAck)
         nxmAddr <= curAddr;
   end

   // A timed-out cycle is never also acknowledged
   ackNotNxm: assert property (@(posedge clk) disable iff (rst) !(busAck && nxmIntr));
   // CPU holds off while a memory cycle is open
   noStrobeInWait: assert property (@(posedge clk) disable iff (rst) busReq |-> !memWait);

endmodule
